/* Makefile */
# Verilator flow for the machine-mode trap unit.
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINT      ?= --lint-only --timing --assert
TOP       ?= mtrap_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass line shows up in the output.
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep "TESTS PASSED" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
src/mtrap_pkg.sv
src/csr_rmw.sv
src/csr_file.sv
src/trap_arbiter.sv
src/mtrap_unit.sv
dv/mtrap_props.sv
dv/mtrap_tb.sv

/* dv/mtrap_props.sv */
// Bound into csr_file, reaches its state registers by name.
// Assertions are off while rst_n is low.
`timescale 1ns/1ps
`default_nettype none

module mtrap_props import mtrap_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input csr_req_t        csr_req,
    input logic            we,
    input trap_t           trap,
    input logic            illegal,
    input logic            mie_bit,
    input logic [xlen-1:0] mie_reg,
    input logic [xlen-1:2] mtvec_reg,
    input logic [xlen-1:0] mscratch_reg
);

    // Only the six Zicsr funct3 codes arrive with valid.
    assert property (@(posedge clk) disable iff (!rst_n)
        csr_req.valid |-> csr_req.op inside {csr_op_rw, csr_op_rs, csr_op_rc,
                                             csr_op_rwi, csr_op_rsi, csr_op_rci})
    else $error("CSR request carries a non-CSR funct3");

    // Trap entry masks interrupts.
    assert property (@(posedge clk) disable iff (!rst_n)
        trap.take |=> !mie_bit)
    else $error("mstatus.MIE still set after trap entry");

    // A write in a trap cycle is dropped.
    assert property (@(posedge clk) disable iff (!rst_n)
        (trap.take && we) |=> (mie_reg == $past(mie_reg)) && (mtvec_reg == $past(mtvec_reg))
                              && (mscratch_reg == $past(mscratch_reg)))
    else $error("CSR write took effect in a trap cycle");

    // Illegal access always traps.
    assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> trap.take)
    else $error("illegal CSR access without a trap");

endmodule

bind csr_file mtrap_props i_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_req      (csr_req),
    .we           (we),
    .trap         (trap),
    .illegal      (illegal),
    .mie_bit      (mstatus_mie_q),
    .mie_reg      (mie_q),
    .mtvec_reg    (mtvec_q),
    .mscratch_reg (mscratch_q)
);

`default_nettype wire

/* dv/mtrap_tb.sv */
// Directed tests for mtrap_unit; inputs change on the falling edge.
// Outputs are sampled 2 ns after the falling edge.
`timescale 1ns/1ps
`default_nettype none

module mtrap_tb import mtrap_pkg::*; ();

    localparam logic [xlen-1:0] test_hart_id = 32'h0000_00a5;
    localparam logic [15:0]     lfsr_seed    = 16'd14986;
    localparam int              num_tests    = 5;
    localparam int              test_cycles  = 120;
    localparam int              timeout_ns   = (16 + num_tests * test_cycles) * 10;
    localparam logic [xlen-1:1] base_pc      = 31'h0000_0200;

    logic               clk;
    logic               rst_n;
    csr_req_t           csr_req;
    exc_req_t           exc_req;
    logic [num_irq-1:0] irq;
    logic [xlen-1:0]    csr_rdata;
    logic               csr_illegal;
    trap_t              trap;
    logic [xlen-1:2]    trap_vec;
    logic [xlen-1:1]    epc;
    logic [15:0]        lfsr_state;
    // Last sampled response.
    logic [xlen-1:0]    rd_data;
    logic               rd_illegal;
    trap_t              rd_trap;

    mtrap_unit #(
        .hart_id (test_hart_id)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_req     (csr_req),
        .exc_req     (exc_req),
        .irq         (irq),
        .csr_rdata   (csr_rdata),
        .csr_illegal (csr_illegal),
        .trap        (trap),
        .trap_vec    (trap_vec),
        .epc         (epc)
    );

    always #5 clk = ~clk;

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step per bit taken.
    task automatic rand_bits(input int n, output logic [31:0] w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%08h exp=%08h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic check_trap(input trap_t t, input logic is_int, input logic [4:0] cause,
                              input logic [xlen-1:1] pc);
        check("trap.take", 32'(t.take), 32'h1);
        check("trap.is_int", 32'(t.is_int), 32'(is_int));
        check("trap.cause", 32'(t.cause), 32'(cause));
        check("trap.pc", {t.pc, 1'b0}, {pc, 1'b0});
    endtask

    // One-cycle CSR strobe, then idle.
    task automatic access_csr(input csr_op_t op, input logic [11:0] addr, input logic [4:0] idx,
                              input logic [31:0] val, input logic [xlen-1:1] pc);
        @(negedge clk);
        csr_req.valid   = 1'b1;
        csr_req.op      = op;
        csr_req.addr    = addr;
        csr_req.rs1_idx = idx;
        csr_req.rs1_val = val;
        csr_req.pc      = pc;
        #2;
        rd_data    = csr_rdata;
        rd_illegal = csr_illegal;
        rd_trap    = trap;
        @(negedge clk);
        csr_req = '0;
    endtask

    // CSRRS with x0 never writes.
    task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
        access_csr(csr_op_rs, addr, 5'd0, 32'h0, base_pc);
        check("csr_illegal", 32'(rd_illegal), 32'h0);
        check("trap.take", 32'(rd_trap.take), 32'h0);
        data = rd_data;
    endtask

    task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
        access_csr(csr_op_rw, addr, 5'd1, data, base_pc);
        check("csr_illegal", 32'(rd_illegal), 32'h0);
        check("trap.take", 32'(rd_trap.take), 32'h0);
    endtask

    // Counts trap cycles, keeping the last one.
    task automatic count_traps(input int cycles, output int takes, output trap_t seen);
        takes = 0;
        seen  = '0;
        repeat (cycles) begin
            #2;
            if (trap.take) begin
                takes++;
                seen = trap;
            end
            @(negedge clk);
        end
    endtask

    // Runs with all irq lines still high.
    task automatic reset_state();
        logic [31:0] got;
        read_csr(csr_mstatus, got);
        check("mstatus", got, 32'h0);
        read_csr(csr_mie, got);
        check("mie", got, 32'h0);
        read_csr(csr_mtvec, got);
        check("mtvec", got, 32'h0);
        read_csr(csr_mcause, got);
        check("mcause", got, 32'h0);
        read_csr(csr_misa, got);
        check("misa", got, misa_value);
        read_csr(csr_mhartid, got);
        check("mhartid", got, test_hart_id);
        irq = '0;
    endtask

    task automatic rmw_ops();
        csr_op_t     ops [6];
        logic [31:0] model;
        logic [31:0] val;
        logic [31:0] word;
        logic [31:0] operand;
        logic [31:0] expect_val;
        logic [31:0] got;
        logic [4:0]  idx;
        ops   = '{csr_op_rw, csr_op_rs, csr_op_rc, csr_op_rwi, csr_op_rsi, csr_op_rci};
        model = 32'h0;
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 6; k++) begin
                rand_bits(32, val);
                rand_bits(5, word);
                idx        = word[4:0];
                operand    = (ops[k] inside {csr_op_rwi, csr_op_rsi, csr_op_rci}) ?
                             {27'd0, idx} : val;
                expect_val = model;
                if (ops[k] inside {csr_op_rw, csr_op_rwi}) begin
                    expect_val = operand;
                end else if (idx != 5'd0) begin
                    expect_val = (ops[k] inside {csr_op_rs, csr_op_rsi}) ?
                                 (model | operand) : (model & ~operand);
                end
                access_csr(ops[k], csr_mscratch, idx, val, base_pc);
                check("csr_rdata", rd_data, model);
                check("csr_illegal", 32'(rd_illegal), 32'h0);
                model = expect_val;
                read_csr(csr_mscratch, got);
                check("mscratch", got, model);
            end
        end
        // Set with x0 and a nonzero operand is a pure read.
        access_csr(csr_op_rs, csr_mscratch, 5'd0, val | 32'h1, base_pc);
        check("csr_rdata", rd_data, model);
        read_csr(csr_mscratch, got);
        check("mscratch", got, model);
    endtask

    task automatic illegal_access();
        logic [31:0] got;
        access_csr(csr_op_rw, csr_mvendorid, 5'd3, 32'hdead_beef, base_pc + 31'h10);
        check("csr_illegal", 32'(rd_illegal), 32'h1);
        check_trap(rd_trap, 1'b0, 5'd2, base_pc + 31'h10);
        check("epc", {epc, 1'b0}, {base_pc + 31'h10, 1'b0});
        read_csr(csr_mvendorid, got);
        check("mvendorid", got, 32'h0);
        read_csr(csr_mcause, got);
        check("mcause", got, 32'h0000_0002);
        // 0x7c0 is not implemented.
        access_csr(csr_op_rs, 12'h7c0, 5'd0, 32'h0, base_pc + 31'h20);
        check("csr_illegal", 32'(rd_illegal), 32'h1);
        check_trap(rd_trap, 1'b0, 5'd2, base_pc + 31'h20);
        check("epc", {epc, 1'b0}, {base_pc + 31'h20, 1'b0});
    endtask

    task automatic exception_priority();
        logic [31:0] vec;
        logic [31:0] got;
        rand_bits(32, vec);
        vec[1:0] = 2'b00;
        write_csr(csr_mtvec, vec);
        write_csr(csr_mie, 32'h1 << 20);
        write_csr(csr_mscratch, 32'h1357_9bdf);
        write_csr(csr_mstatus, 32'h8);
        // Line 4, an exception and an mscratch write in the same cycle.
        @(negedge clk);
        irq             = 16'h0010;
        exc_req.valid   = 1'b1;
        exc_req.cause   = 5'd7;
        exc_req.pc      = base_pc + 31'h40;
        csr_req.valid   = 1'b1;
        csr_req.op      = csr_op_rw;
        csr_req.addr    = csr_mscratch;
        csr_req.rs1_idx = 5'd1;
        csr_req.rs1_val = 32'hffff_0000;
        csr_req.pc      = base_pc + 31'h44;
        #2;
        check_trap(trap, 1'b0, 5'd7, base_pc + 31'h40);
        check("csr_illegal", 32'(csr_illegal), 32'h0);
        check("trap_vec", {trap_vec, 2'b00}, vec);
        @(negedge clk);
        exc_req.valid = 1'b0;
        csr_req       = '0;
        #2;
        check("trap.take", 32'(trap.take), 32'h0);
        @(negedge clk);
        irq = '0;
        check("epc", {epc, 1'b0}, {base_pc + 31'h40, 1'b0});
        read_csr(csr_mcause, got);
        check("mcause", got, 32'h0000_0007);
        read_csr(csr_mstatus, got);
        check("mstatus", got, 32'h0000_0080);
        // The write in the trap cycle is dropped.
        read_csr(csr_mscratch, got);
        check("mscratch", got, 32'h1357_9bdf);
    endtask

    task automatic interrupt_entry();
        int          takes;
        trap_t       seen;
        logic [31:0] got;
        // Lines 2, 5 and 9 enabled.
        write_csr(csr_mie, 32'h0224_0000);
        write_csr(csr_mstatus, 32'h8);
        @(negedge clk);
        exc_req.pc = base_pc + 31'h80;
        irq        = 16'h0224;
        count_traps(6, takes, seen);
        check("irq trap cycles", 32'(takes), 32'h1);
        check_trap(seen, 1'b1, 5'd18, base_pc + 31'h80);
        check("epc", {epc, 1'b0}, {base_pc + 31'h80, 1'b0});
        read_csr(csr_mcause, got);
        check("mcause", got, 32'h8000_0012);
        read_csr(csr_mstatus, got);
        check("mstatus", got, 32'h0000_0080);
        // Line 2 served, unmask for the next one.
        irq = 16'h0220;
        write_csr(csr_mstatus, 32'h8);
        count_traps(6, takes, seen);
        check("irq trap cycles", 32'(takes), 32'h1);
        check_trap(seen, 1'b1, 5'd21, base_pc + 31'h80);
        read_csr(csr_mcause, got);
        check("mcause", got, 32'h8000_0015);
        irq = '0;
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        csr_req    = '0;
        exc_req    = '0;
        irq        = '1;
        lfsr_state = lfsr_seed;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_state();
        rmw_ops();
        illegal_access();
        exception_priority();
        interrupt_entry();
        $display("TESTS PASSED");
        $finish;
    end

    // Budget of test_cycles per test plus reset.
    initial begin
        #(timeout_ns);
        $display("Timeout: the tests did not finish in time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* src/csr_file.sv */
// Machine CSRs; misa, medeleg, mideleg, mstatush, mip and mtval ignore writes.
// Trap entry wins over a CSR write in the same cycle.
`timescale 1ns/1ps
`default_nettype none

module csr_file import mtrap_pkg::*; #(
    parameter logic [xlen-1:0] hart_id = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_req_t           csr_req,
    input  logic [num_irq-1:0] irq,
    input  logic [xlen-1:0]    wdata,
    input  logic               we,
    input  trap_t              trap,
    output logic [xlen-1:0]    rdata,
    output logic               illegal,
    output logic [xlen-1:0]    irq_en,
    output logic [xlen-1:0]    mip,
    output logic [xlen-1:2]    mtvec,
    output logic [xlen-1:1]    mepc
);

    // Only MIE and MPIE of mstatus exist.
    logic            mstatus_mie_q;
    logic            mstatus_mpie_q;
    logic [xlen-1:0] mie_q;
    // Direct mode only, low bits read as zero.
    logic [xlen-1:2] mtvec_q;
    logic [xlen-1:0] mscratch_q;
    logic [xlen-1:1] mepc_q;
    // mcause split into flag and code.
    logic            mcause_int_q;
    logic [4:0]      mcause_code_q;

    logic [xlen-1:0] mstatus_rd;
    logic [xlen-1:0] mcause_rd;
    logic            csr_exists;
    logic            csr_writable;

    // Assemble mstatus from its two live bits.
    always_comb begin
        mstatus_rd                   = '0;
        mstatus_rd[mstatus_mie_bit]  = mstatus_mie_q;
        mstatus_rd[mstatus_mpie_bit] = mstatus_mpie_q;
    end

    // Interrupt flag on top, cause in the low bits.
    assign mcause_rd = {mcause_int_q, {(xlen-6){1'b0}}, mcause_code_q};

    // External lines sit at their cause positions.
    always_comb begin
        mip                      = '0;
        mip[irq_base +: num_irq] = irq;
    end

    // Read mux and access rights.
    always_comb begin
        csr_exists   = 1'b1;
        csr_writable = 1'b1;
        rdata        = '0;
        case (csr_req.addr)
            csr_mstatus:  rdata = mstatus_rd;
            csr_misa:     rdata = misa_value;
            // Hardwired zero, writes dropped.
            csr_medeleg,
            csr_mideleg,
            csr_mstatush,
            csr_mtval:    rdata = '0;
            csr_mie:      rdata = mie_q;
            csr_mtvec:    rdata = {mtvec_q, 2'b00};
            csr_mip:      rdata = mip;
            csr_mscratch: rdata = mscratch_q;
            csr_mepc:     rdata = {mepc_q, 1'b0};
            csr_mcause:   rdata = mcause_rd;
            // Read-only zeros.
            csr_mvendorid,
            csr_marchid,
            csr_mimpid,
            csr_mconfigptr: csr_writable = 1'b0;
            csr_mhartid: begin
                csr_writable = 1'b0;
                rdata        = hart_id;
            end
            default: begin
                csr_exists   = 1'b0;
                csr_writable = 1'b0;
            end
        endcase
    end

    // Missing CSR, or a write to a read-only one.
    assign illegal = csr_req.valid && (!csr_exists || (we && !csr_writable));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q          <= '0;
            mtvec_q        <= '0;
            mscratch_q     <= '0;
            mepc_q         <= '0;
            mcause_int_q   <= 1'b0;
            mcause_code_q  <= '0;
        end else if (trap.take) begin
            // Trap entry.
            // Old MIE saved, interrupts masked.
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
            mepc_q         <= trap.pc;
            mcause_int_q   <= trap.is_int;
            mcause_code_q  <= trap.cause;
        end else if (we) begin
            case (csr_req.addr)
                csr_mstatus: begin
                    mstatus_mie_q  <= wdata[mstatus_mie_bit];
                    mstatus_mpie_q <= wdata[mstatus_mpie_bit];
                end
                csr_mie:      mie_q      <= wdata;
                csr_mtvec:    mtvec_q    <= wdata[xlen-1:2];
                csr_mscratch: mscratch_q <= wdata;
                csr_mepc:     mepc_q     <= wdata[xlen-1:1];
                csr_mcause: begin
                    mcause_int_q  <= wdata[xlen-1];
                    mcause_code_q <= wdata[4:0];
                end
                // Ignored or read-only targets.
                default: ;
            endcase
        end
    end

    // Per-line enables, masked globally by MIE.
    assign irq_en = mstatus_mie_q ? mie_q : '0;

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

endmodule

`default_nettype wire

/* src/csr_rmw.sv */
// Read-modify-write for Zicsr instructions.
// Unknown funct3 codes never write.
`timescale 1ns/1ps
`default_nettype none

module csr_rmw import mtrap_pkg::*; (
    input  csr_req_t        csr_req,
    input  logic [xlen-1:0] old,
    output logic [xlen-1:0] wdata,
    output logic            we
);

    logic            is_imm;
    logic            do_write;
    logic            do_set;
    logic            do_clear;
    logic [xlen-1:0] operand;

    // Decode the operation.
    always_comb begin
        is_imm   = 1'b0;
        do_write = 1'b0;
        do_set   = 1'b0;
        do_clear = 1'b0;
        case (csr_req.op)
            csr_op_rw:  do_write = 1'b1;
            csr_op_rs:  do_set   = 1'b1;
            csr_op_rc:  do_clear = 1'b1;
            csr_op_rwi: begin
                is_imm   = 1'b1;
                do_write = 1'b1;
            end
            csr_op_rsi: begin
                is_imm = 1'b1;
                do_set = 1'b1;
            end
            csr_op_rci: begin
                is_imm   = 1'b1;
                do_clear = 1'b1;
            end
            default: ;
        endcase
    end

    // Immediate forms take the 5-bit field, zero-extended.
    assign operand = is_imm ? {{(xlen-5){1'b0}}, csr_req.rs1_idx} : csr_req.rs1_val;

    always_comb begin
        if (do_set) begin
            wdata = old | operand;
        end else if (do_clear) begin
            wdata = old & ~operand;
        end else begin
            wdata = operand;
        end
    end

    // Set and clear with x0 or a zero immediate are pure reads.
    assign we = csr_req.valid && (do_write || ((do_set || do_clear) && csr_req.rs1_idx != 5'd0));

endmodule

`default_nettype wire

/* src/mtrap_pkg.sv */
// Machine-mode only, RV32, direct-mode mtvec.
// Interrupt line n is reported with cause irq_base + n.
`default_nettype none

package mtrap_pkg;

    // Data word width.
    localparam int xlen = 32;

    // Machine CSR numbers.
    localparam logic [11:0] csr_mstatus    = 12'h300;
    localparam logic [11:0] csr_misa       = 12'h301;
    localparam logic [11:0] csr_medeleg    = 12'h302;
    localparam logic [11:0] csr_mideleg    = 12'h303;
    localparam logic [11:0] csr_mie        = 12'h304;
    localparam logic [11:0] csr_mtvec      = 12'h305;
    localparam logic [11:0] csr_mstatush   = 12'h310;
    localparam logic [11:0] csr_mscratch   = 12'h340;
    localparam logic [11:0] csr_mepc       = 12'h341;
    localparam logic [11:0] csr_mcause     = 12'h342;
    localparam logic [11:0] csr_mtval      = 12'h343;
    localparam logic [11:0] csr_mip        = 12'h344;
    // Read-only identification block.
    localparam logic [11:0] csr_mvendorid  = 12'hf11;
    localparam logic [11:0] csr_marchid    = 12'hf12;
    localparam logic [11:0] csr_mimpid     = 12'hf13;
    localparam logic [11:0] csr_mhartid    = 12'hf14;
    localparam logic [11:0] csr_mconfigptr = 12'hf15;

    // MXL of 1, extensions I and M.
    localparam logic [xlen-1:0] misa_value = 32'h4000_1100;

    // Illegal instruction exception.
    localparam logic [4:0] cause_illegal = 5'd2;
    // Cause of interrupt line 0.
    localparam logic [4:0] irq_base = 5'd16;
    // External interrupt lines.
    localparam int num_irq = 16;

    // Interrupt enable bits in mstatus.
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;

    // Funct3 of the Zicsr instructions.
    typedef enum logic [2:0] {
        csr_op_rw  = 3'b001,
        csr_op_rs  = 3'b010,
        csr_op_rc  = 3'b011,
        csr_op_rwi = 3'b101,
        csr_op_rsi = 3'b110,
        csr_op_rci = 3'b111
    } csr_op_t;

    // One CSR instruction from execute.
    // rs1_idx doubles as the zero-extended immediate.
    typedef struct packed {
        logic            valid;
        csr_op_t         op;
        logic [11:0]     addr;
        logic [4:0]      rs1_idx;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:1] pc;
    } csr_req_t;

    // Exception raised elsewhere in the pipeline.
    // pc carries the current pc even when not valid.
    typedef struct packed {
        logic            valid;
        logic [4:0]      cause;
        logic [xlen-1:1] pc;
    } exc_req_t;

    // Trap being taken this cycle.
    typedef struct packed {
        logic            take;
        logic            is_int;
        logic [4:0]      cause;
        logic [xlen-1:1] pc;
    } trap_t;

endpackage

`default_nettype wire

/* src/mtrap_unit.sv */
// Standalone M-mode trap and CSR unit, meant to sit beside execute.
// No MRET; software restores mstatus and returns to epc.
`timescale 1ns/1ps
`default_nettype none

module mtrap_unit import mtrap_pkg::*; #(
    parameter logic [xlen-1:0] hart_id = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_req_t           csr_req,
    input  exc_req_t           exc_req,
    input  logic [num_irq-1:0] irq,
    output logic [xlen-1:0]    csr_rdata,
    output logic               csr_illegal,
    output trap_t              trap,
    output logic [xlen-1:2]    trap_vec,
    output logic [xlen-1:1]    epc
);

    // Write port from the RMW logic.
    logic [xlen-1:0] csr_wdata;
    logic            csr_we;
    // Interrupt state for the arbiter.
    logic [xlen-1:0] irq_en;
    logic [xlen-1:0] mip;

    // CSR state and read port.
    csr_file #(
        .hart_id (hart_id)
    ) i_csr_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .csr_req (csr_req),
        .irq     (irq),
        .wdata   (csr_wdata),
        .we      (csr_we),
        .trap    (trap),
        .rdata   (csr_rdata),
        .illegal (csr_illegal),
        .irq_en  (irq_en),
        .mip     (mip),
        .mtvec   (trap_vec),
        .mepc    (epc)
    );

    // New value from the old read value.
    csr_rmw i_csr_rmw (
        .csr_req (csr_req),
        .old     (csr_rdata),
        .wdata   (csr_wdata),
        .we      (csr_we)
    );

    // One trap per cycle.
    trap_arbiter i_trap_arbiter (
        .exc_req     (exc_req),
        .csr_req     (csr_req),
        .csr_illegal (csr_illegal),
        .irq_en      (irq_en),
        .mip         (mip),
        .trap        (trap)
    );

endmodule

`default_nettype wire

/* src/trap_arbiter.sv */
// Priority is exception, then illegal CSR access, then lowest enabled interrupt.
`timescale 1ns/1ps
`default_nettype none

module trap_arbiter import mtrap_pkg::*; (
    input  exc_req_t        exc_req,
    input  csr_req_t        csr_req,
    input  logic            csr_illegal,
    input  logic [xlen-1:0] irq_en,
    input  logic [xlen-1:0] mip,
    output trap_t           trap
);

    logic [num_irq-1:0] pending;
    logic               irq_hit;
    logic [4:0]         irq_line;

    // Only the external lines can be pending.
    assign pending = mip[irq_base +: num_irq] & irq_en[irq_base +: num_irq];
    assign irq_hit = |pending;

    // Lowest numbered line wins.
    always_comb begin
        irq_line = '0;
        for (int i = num_irq - 1; i >= 0; i--) begin
            if (pending[i]) begin
                irq_line = 5'(i);
            end
        end
    end

    always_comb begin
        trap = '0;
        if (exc_req.valid) begin
            // Pipeline exception.
            trap.take  = 1'b1;
            trap.cause = exc_req.cause;
            trap.pc    = exc_req.pc;
        end else if (csr_illegal) begin
            trap.take  = 1'b1;
            trap.cause = cause_illegal;
            trap.pc    = csr_req.pc;
        end else if (irq_hit) begin
            trap.take   = 1'b1;
            trap.is_int = 1'b1;
            trap.cause  = irq_base + irq_line;
            // The instruction in execute is the one to resume.
            trap.pc     = csr_req.valid ? csr_req.pc : exc_req.pc;
        end
    end

endmodule

`default_nettype wire
